/* vec_alu_pkg.sv */
package vec_alu_pkg;

    // ------------------------------------------------------------------
    // Widths
    // ------------------------------------------------------------------
    localparam int data_w    = 128;
    localparam int max_lanes = 16;
    localparam int lane_w    = 32;  // Lanes run sign extended to this width
    localparam int rd_w      = 5;

    // ------------------------------------------------------------------
    // Codes
    // ------------------------------------------------------------------
    typedef enum logic [3:0] {
        op_add    = 4'd0,
        op_sub    = 4'd1,
        op_sll    = 4'd2,
        op_sra    = 4'd3,
        op_xor    = 4'd4,
        op_or     = 4'd5,
        op_and    = 4'd6,
        op_min    = 4'd7,
        op_max    = 4'd8,
        op_cmpeq  = 4'd9,
        op_cmplt  = 4'd10,
        op_cmpltu = 4'd11
    } op_kind_t;

    typedef enum logic [1:0] {
        et_i32 = 2'd0,
        et_i16 = 2'd1,
        et_i8  = 2'd2
    } elem_type_t;

    // ------------------------------------------------------------------
    // Pipeline payloads
    // ------------------------------------------------------------------
    typedef struct packed {
        op_kind_t                          op_kind;
        elem_type_t                        elem_type;
        logic                              vm_enable;
        logic [max_lanes-1:0]              vmask;
        logic                              dest_scalar;
        logic                              illegal;
        logic [rd_w-1:0]                   rd;
        logic [max_lanes-1:0][lane_w-1:0]  a_elem;
        logic [max_lanes-1:0][lane_w-1:0]  b_elem;
    } vec_req_t;

    typedef struct packed {
        logic [max_lanes-1:0][lane_w-1:0]  r_elem;
        logic [max_lanes-1:0]              cmp_mask;
        elem_type_t                        elem_type;
        logic                              dest_scalar;
        logic                              is_cmp;
        logic                              illegal;
        logic [rd_w-1:0]                   rd;
    } vec_lane_res_t;

    typedef struct packed {
        logic [data_w-1:0] data;
        logic [rd_w-1:0]   rd;
        logic              is_scalar;
        logic              err_illegal;
    } vec_wb_t;

    function automatic int elem_bits(elem_type_t et);
        case (et)
            et_i16:  return 16;
            et_i8:   return 8;
            default: return 32;
        endcase
    endfunction

    function automatic int lane_count(elem_type_t et);
        return data_w / elem_bits(et);
    endfunction

endpackage

/* vec_op_if.sv */
`timescale 1ns/1ps

interface vec_op_if
    import vec_alu_pkg::*;
();

    op_kind_t             op_kind;
    elem_type_t           elem_type;
    logic                 vm_enable;
    logic [max_lanes-1:0] vmask;
    logic                 dest_scalar;
    logic                 illegal;    // Unknown op or element type

    modport ctrl (
        output op_kind,
        output elem_type,
        output vm_enable,
        output vmask,
        output dest_scalar,
        output illegal
    );

    modport dp (
        input op_kind,
        input elem_type,
        input vm_enable,
        input vmask,
        input dest_scalar,
        input illegal
    );

endinterface

/* vec_stage.sv */
`timescale 1ns/1ps

module vec_stage #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  payload_t in_data,
    output logic     out_valid,
    input  logic     out_ready,
    output payload_t out_data
);

    logic     full;
    payload_t data_q;

    // Take a new item when empty or when the held one leaves this cycle
    assign in_ready  = !full || out_ready;
    assign out_valid = full;
    assign out_data  = data_q;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            full <= 1'b0;
        end else if (in_ready) begin
            full <= in_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready) begin
            data_q <= in_data;
        end
    end

    // ------------------------------------------------------------------
    // Handshake checks
    // ------------------------------------------------------------------
    a_hold_in: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_data))
        else $error("vec_stage: upstream valid or data changed before transfer");

    a_hold_data: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> $stable(out_data))
        else $error("vec_stage: out_data changed while stalled");

endmodule

/* vec_alu_ctrl.sv */
`timescale 1ns/1ps

module vec_alu_ctrl
    import vec_alu_pkg::*;
(
    input  logic [3:0]           op,
    input  logic [1:0]           elem_type,
    input  logic                 vm_enable,
    input  logic [max_lanes-1:0] vmask,
    input  logic                 dest_scalar,
    vec_op_if.ctrl               op_bus
);

    logic       op_bad;
    logic       type_bad;
    op_kind_t   op_dec;
    elem_type_t type_dec;

    // Op field, codes 12..15 are unused
    always_comb begin
        op_bad = 1'b0;
        case (op)
            4'd0:  op_dec = op_add;
            4'd1:  op_dec = op_sub;
            4'd2:  op_dec = op_sll;
            4'd3:  op_dec = op_sra;
            4'd4:  op_dec = op_xor;
            4'd5:  op_dec = op_or;
            4'd6:  op_dec = op_and;
            4'd7:  op_dec = op_min;
            4'd8:  op_dec = op_max;
            4'd9:  op_dec = op_cmpeq;
            4'd10: op_dec = op_cmplt;
            4'd11: op_dec = op_cmpltu;
            default: begin
                op_dec = op_add;
                op_bad = 1'b1;
            end
        endcase
    end

    always_comb begin
        type_bad = 1'b0;
        case (elem_type)
            2'd0:    type_dec = et_i32;
            2'd1:    type_dec = et_i16;
            2'd2:    type_dec = et_i8;
            default: begin
                type_dec = et_i32;  // Code 3 has no lanes
                type_bad = 1'b1;
            end
        endcase
    end

    assign op_bus.op_kind     = op_dec;
    assign op_bus.elem_type   = type_dec;
    assign op_bus.illegal     = op_bad || type_bad;
    assign op_bus.vm_enable   = vm_enable && !(op_bad || type_bad);
    assign op_bus.vmask       = vmask;
    assign op_bus.dest_scalar = dest_scalar;

endmodule

/* vec_lane_unpack.sv */
`timescale 1ns/1ps

module vec_lane_unpack
    import vec_alu_pkg::*;
(
    vec_op_if.dp              op_bus,
    input  logic [rd_w-1:0]   rd_idx,
    input  logic [data_w-1:0] src_a,
    input  logic [data_w-1:0] src_b,
    output vec_req_t          req
);

    always_comb begin
        req.op_kind     = op_bus.op_kind;
        req.elem_type   = op_bus.elem_type;
        req.vm_enable   = op_bus.vm_enable;
        req.vmask       = op_bus.vmask;
        req.dest_scalar = op_bus.dest_scalar;
        req.illegal     = op_bus.illegal;
        req.rd          = rd_idx;

        req.a_elem = '0;  // Unused upper lanes stay zero
        req.b_elem = '0;

        case (op_bus.elem_type)
            et_i16: begin
                for (int i = 0; i < 8; i++) begin
                    req.a_elem[i] = {{16{src_a[i*16+15]}}, src_a[i*16 +: 16]};
                    req.b_elem[i] = {{16{src_b[i*16+15]}}, src_b[i*16 +: 16]};
                end
            end
            et_i8: begin
                for (int i = 0; i < 16; i++) begin
                    req.a_elem[i] = {{24{src_a[i*8+7]}}, src_a[i*8 +: 8]};
                    req.b_elem[i] = {{24{src_b[i*8+7]}}, src_b[i*8 +: 8]};
                end
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    req.a_elem[i] = src_a[i*32 +: 32];
                    req.b_elem[i] = src_b[i*32 +: 32];
                end
            end
        endcase
    end

endmodule

/* vec_lane_alu.sv */
`timescale 1ns/1ps

module vec_lane_alu
    import vec_alu_pkg::*;
(
    input  vec_req_t      req,
    output vec_lane_res_t res
);

    logic is_cmp;

    assign is_cmp = req.op_kind inside {op_cmpeq, op_cmplt, op_cmpltu};

    always_comb begin
        int                       lanes;
        logic signed [lane_w-1:0] sa;
        logic signed [lane_w-1:0] sb;
        logic [lane_w-1:0]        r;
        logic                     c;

        lanes = lane_count(req.elem_type);

        res.r_elem      = '0;
        res.cmp_mask    = '0;
        res.elem_type   = req.elem_type;
        res.dest_scalar = req.dest_scalar;
        res.is_cmp      = is_cmp;
        res.illegal     = req.illegal;
        res.rd          = req.rd;

        for (int i = 0; i < max_lanes; i++) begin
            sa = req.a_elem[i];
            sb = req.b_elem[i];
            r  = '0;
            c  = 1'b0;

            case (req.op_kind)
                op_add:    r = sa + sb;
                op_sub:    r = sa - sb;
                op_sll:    r = sa << sb[4:0];
                op_sra:    r = sa >>> sb[4:0];   // Sign fill from the extended lane
                op_xor:    r = sa ^ sb;
                op_or:     r = sa | sb;
                op_and:    r = sa & sb;
                op_min:    r = (sa < sb) ? sa : sb;
                op_max:    r = (sa > sb) ? sa : sb;
                op_cmpeq:  c = (sa == sb);
                op_cmplt:  c = (sa < sb);
                op_cmpltu: c = ($unsigned(sa) < $unsigned(sb));
                default:   r = '0;
            endcase

            if (is_cmp) begin
                r = {lane_w{c}};
            end

            // Masked-off lane keeps a and drops out of the compare mask
            if (req.vm_enable && !req.vmask[i]) begin
                r = sa;
                c = 1'b0;
            end

            if (i < lanes && !req.illegal) begin
                res.r_elem[i]   = r;
                res.cmp_mask[i] = c;
            end
        end
    end

endmodule

/* vec_result_pack.sv */
`timescale 1ns/1ps

module vec_result_pack
    import vec_alu_pkg::*;
(
    input  vec_lane_res_t res,
    output vec_wb_t       wb
);

    always_comb begin
        int lanes;

        lanes = lane_count(res.elem_type);

        // Lane 0 sits in the low bits
        wb.data = '0;
        case (res.elem_type)
            et_i16: begin
                for (int i = 0; i < 8; i++) begin
                    wb.data[i*16 +: 16] = res.r_elem[i][15:0];
                end
            end
            et_i8: begin
                for (int i = 0; i < 16; i++) begin
                    wb.data[i*8 +: 8] = res.r_elem[i][7:0];
                end
            end
            default: begin
                for (int i = 0; i < 4; i++) begin
                    wb.data[i*32 +: 32] = res.r_elem[i];
                end
            end
        endcase

        // Scalar compare: one mask bit per lane, rest zero
        if (res.is_cmp && res.dest_scalar) begin
            wb.data = '0;
            for (int i = 0; i < max_lanes; i++) begin
                if (i < lanes) begin
                    wb.data[i] = res.cmp_mask[i];
                end
            end
        end

        if (res.illegal) begin
            wb.data = '0;
        end

        wb.rd          = res.rd;
        wb.is_scalar   = res.dest_scalar;
        wb.err_illegal = res.illegal;
    end

endmodule

/* vec_alu_top.sv */
`timescale 1ns/1ps

module vec_alu_top
    import vec_alu_pkg::*;
(
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 in_valid,
    input  logic [3:0]           op,
    input  logic [1:0]           elem_type,
    input  logic                 vm_enable,
    input  logic [max_lanes-1:0] vmask,
    input  logic                 dest_scalar,
    input  logic [rd_w-1:0]      rd_idx,
    input  logic [data_w-1:0]    src_a,
    input  logic [data_w-1:0]    src_b,
    input  logic                 wb_ready,
    output logic                 in_ready,
    output logic                 wb_valid,
    output logic [rd_w-1:0]      wb_rd,
    output logic                 wb_is_scalar,
    output logic [data_w-1:0]    wb_data,
    output logic                 wb_err_illegal
);

    vec_req_t      req_d;
    vec_req_t      req_q;
    logic          req_valid;
    logic          req_ready;
    vec_lane_res_t lane_res;
    vec_wb_t       wb_d;
    vec_wb_t       wb_q;

    vec_op_if op_bus ();

    // ------------------------------------------------------------------
    // Stage 1: decode, unpack, register
    // ------------------------------------------------------------------
    vec_alu_ctrl u_ctrl (
        .op          (op),
        .elem_type   (elem_type),
        .vm_enable   (vm_enable),
        .vmask       (vmask),
        .dest_scalar (dest_scalar),
        .op_bus      (op_bus.ctrl)
    );

    vec_lane_unpack u_unpack (
        .op_bus (op_bus.dp),
        .rd_idx (rd_idx),
        .src_a  (src_a),
        .src_b  (src_b),
        .req    (req_d)
    );

    vec_stage #(.payload_t(vec_req_t)) req_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_data   (req_d),
        .out_valid (req_valid),
        .out_ready (req_ready),
        .out_data  (req_q)
    );

    // ------------------------------------------------------------------
    // Stage 2: lane compute, pack, writeback register
    // ------------------------------------------------------------------
    vec_lane_alu u_lane_alu (
        .req (req_q),
        .res (lane_res)
    );

    vec_result_pack u_pack (
        .res (lane_res),
        .wb  (wb_d)
    );

    vec_stage #(.payload_t(vec_wb_t)) wb_stage (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (req_valid),
        .in_ready  (req_ready),
        .in_data   (wb_d),
        .out_valid (wb_valid),
        .out_ready (wb_ready),
        .out_data  (wb_q)
    );

    assign wb_rd          = wb_q.rd;
    assign wb_is_scalar   = wb_q.is_scalar;
    assign wb_data        = wb_q.data;
    assign wb_err_illegal = wb_q.err_illegal;

endmodule

/* tb_vec_alu.sv */
`timescale 1ns/1ps

module tb_vec_alu
    import vec_alu_pkg::*;
();

    localparam int seed     = 16;
    localparam int n_req    = 200;
    localparam int max_wait = 200;  // Cycles before a wait gives up
    localparam int n_tests  = 6;

    logic                 clk;
    logic                 rst_n;
    logic                 in_valid;
    logic [3:0]           op;
    logic [1:0]           elem_type;
    logic                 vm_enable;
    logic [max_lanes-1:0] vmask;
    logic                 dest_scalar;
    logic [rd_w-1:0]      rd_idx;
    logic [data_w-1:0]    src_a;
    logic [data_w-1:0]    src_b;
    logic                 wb_ready;
    logic                 in_ready;
    logic                 wb_valid;
    logic [rd_w-1:0]      wb_rd;
    logic                 wb_is_scalar;
    logic [data_w-1:0]    wb_data;
    logic                 wb_err_illegal;

    vec_wb_t exp_q[$];
    int      errors;
    logic    timed_out;

    vec_alu_top UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .in_valid       (in_valid),
        .op             (op),
        .elem_type      (elem_type),
        .vm_enable      (vm_enable),
        .vmask          (vmask),
        .dest_scalar    (dest_scalar),
        .rd_idx         (rd_idx),
        .src_a          (src_a),
        .src_b          (src_b),
        .wb_ready       (wb_ready),
        .in_ready       (in_ready),
        .wb_valid       (wb_valid),
        .wb_rd          (wb_rd),
        .wb_is_scalar   (wb_is_scalar),
        .wb_data        (wb_data),
        .wb_err_illegal (wb_err_illegal)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // ------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------
    function automatic logic [data_w-1:0] rand128();
        return {$urandom(), $urandom(), $urandom(), $urandom()};
    endfunction

    function automatic vec_wb_t expected_wb(logic [3:0] o, logic [1:0] et, logic vme,
                                            logic [max_lanes-1:0] vm, logic ds,
                                            logic [rd_w-1:0] rd, logic [data_w-1:0] a,
                                            logic [data_w-1:0] b);
        vec_wb_t           w;
        int                bits;
        logic signed [31:0] x;
        logic signed [31:0] y;
        logic [31:0]       r;
        logic [31:0]       m;
        logic              c;
        logic              cmp;

        w.rd          = rd;
        w.is_scalar   = ds;
        w.err_illegal = (o > 4'd11) || (et == 2'd3);
        w.data        = '0;
        cmp           = (o >= 4'd9);
        if (!w.err_illegal) begin
            bits = (et == 2'd0) ? 32 : (et == 2'd1) ? 16 : 8;
            m    = 32'hffff_ffff >> (32 - bits);
            for (int i = 0; i < data_w / bits; i++) begin
                x = 32'(a >> (i * bits));
                x = (x <<< (32 - bits)) >>> (32 - bits);  // Sign extend the element
                y = 32'(b >> (i * bits));
                y = (y <<< (32 - bits)) >>> (32 - bits);
                c = 1'b0;
                r = '0;
                case (o)
                    4'd0:  r = x + y;
                    4'd1:  r = x - y;
                    4'd2:  r = x << y[4:0];
                    4'd3:  r = x >>> y[4:0];
                    4'd4:  r = x ^ y;
                    4'd5:  r = x | y;
                    4'd6:  r = x & y;
                    4'd7:  r = (x < y) ? x : y;
                    4'd8:  r = (x < y) ? y : x;
                    4'd9:  c = (x == y);
                    4'd10: c = (x < y);
                    default: c = ($unsigned(x) < $unsigned(y));
                endcase
                if (cmp) begin
                    r = c ? 32'hffff_ffff : 32'h0;
                end
                if (vme && !vm[i]) begin
                    r = x;
                    c = 1'b0;
                end
                if (cmp && ds) begin
                    w.data[i] = c;
                end else begin
                    w.data = w.data | (128'(r & m) << (i * bits));
                end
            end
        end
        return w;
    endfunction

    // ------------------------------------------------------------------
    // Compare tasks
    // ------------------------------------------------------------------
    task automatic check_data(input vec_wb_t got, input vec_wb_t exp);
        if (got.data !== exp.data) begin
            $display("FAILED t=%0t wb_data got %h exp %h", $time, got.data, exp.data);
            errors++;
        end
    endtask

    task automatic check_flags(input vec_wb_t got, input vec_wb_t exp);
        if (got.is_scalar !== exp.is_scalar) begin
            $display("FAILED t=%0t wb_is_scalar got %b exp %b", $time,
                     got.is_scalar, exp.is_scalar);
            errors++;
        end
        if (got.err_illegal !== exp.err_illegal) begin
            $display("FAILED t=%0t wb_err_illegal got %b exp %b", $time,
                     got.err_illegal, exp.err_illegal);
            errors++;
        end
    endtask

    task automatic check_tag(input vec_wb_t got, input vec_wb_t exp);
        if (got.rd !== exp.rd) begin
            $display("FAILED t=%0t wb_rd got %0d exp %0d", $time, got.rd, exp.rd);
            errors++;
        end
    endtask

    // ------------------------------------------------------------------
    // Stimulus and collection
    // ------------------------------------------------------------------
    task automatic drive_fields(input int kind);
        rd_idx      = 5'($urandom());
        vmask       = 16'($urandom());
        dest_scalar = 1'($urandom());
        vm_enable   = 1'b0;
        elem_type   = 2'($urandom_range(0, 2));
        src_a       = rand128();
        src_b       = rand128();
        case (kind)
            1: op = 4'($urandom_range(0, 8));
            2: begin
                op = 4'($urandom_range(9, 11));
                if ($urandom_range(0, 1) == 1) begin
                    src_b = src_a ^ (rand128() & rand128() & rand128());  // Some equal lanes
                end
            end
            3: begin
                op        = 4'($urandom_range(0, 11));
                vm_enable = 1'b1;
            end
            4: begin
                vm_enable = 1'($urandom());
                if ($urandom_range(0, 1) == 1) begin
                    op        = 4'($urandom_range(12, 15));
                    elem_type = 2'($urandom_range(0, 3));
                end else begin
                    op        = 4'($urandom_range(0, 15));
                    elem_type = 2'd3;
                end
            end
            default: begin
                op        = 4'($urandom_range(0, 15));
                elem_type = 2'($urandom_range(0, 3));
                vm_enable = 1'($urandom());
            end
        endcase
    endtask

    // Returns on the rising edge where the request transfers
    task automatic wait_accept();
        int waited;

        waited = 0;
        @(negedge clk);  // in_ready has settled mid-cycle
        while (!in_ready && waited < max_wait) begin
            @(negedge clk);
            waited++;
        end
        if (!in_ready) begin
            $display("timeout: in_ready stayed low with a request pending");
            timed_out = 1'b1;
        end else begin
            @(posedge clk);
        end
    endtask

    task automatic send_reqs(input int kind, input int count);
        int k;

        k = 0;
        while (k < count && !timed_out) begin
            drive_fields(kind);
            exp_q.push_back(expected_wb(op, elem_type, vm_enable, vmask, dest_scalar,
                                        rd_idx, src_a, src_b));
            in_valid = 1'b1;
            wait_accept();
            #1;
            k++;
        end
        in_valid = 1'b0;
    endtask

    task automatic collect_results(input int count, input logic bp);
        int      got;
        int      waited;
        vec_wb_t res;
        vec_wb_t exp;

        got      = 0;
        waited   = 0;
        wb_ready = bp ? 1'($urandom_range(0, 1)) : 1'b1;
        while (got < count && !timed_out) begin
            @(negedge clk);
            if (wb_valid && wb_ready) begin
                res.data        = wb_data;
                res.rd          = wb_rd;
                res.is_scalar   = wb_is_scalar;
                res.err_illegal = wb_err_illegal;
                if (exp_q.size() == 0) begin
                    $display("result at t=%0t arrived with no request outstanding", $time);
                    errors++;
                end else begin
                    exp = exp_q.pop_front();
                    check_data(res, exp);
                    check_flags(res, exp);
                    check_tag(res, exp);
                end
                got++;
                waited = 0;
            end else begin
                waited++;
                if (waited > max_wait) begin
                    $display("timeout: no result after %0d cycles", max_wait);
                    timed_out = 1'b1;
                end
            end
            @(posedge clk);
            #1;
            wb_ready = bp ? 1'($urandom_range(0, 1)) : 1'b1;
        end
    endtask

    // Nothing may come out once every request has been answered
    task automatic check_drained();
        wb_ready = 1'b1;
        repeat (4) begin
            @(negedge clk);
            if (wb_valid) begin
                $display("extra result at t=%0t with rd %0d", $time, wb_rd);
                errors++;
            end
        end
        @(posedge clk);
        #1;
        if (exp_q.size() != 0) begin
            $display("%0d expected results never arrived", exp_q.size());
            errors++;
            exp_q.delete();
        end
    endtask

    task automatic run_test(input int id, input string name, input int kind, input logic bp);
        int e0;

        e0 = errors;
        if (!timed_out) begin
            fork
                send_reqs(kind, n_req);
                collect_results(n_req, bp);
            join
            check_drained();
            $display("test %0d %s %0d requests, %0d errors", id, name, n_req, errors - e0);
        end
    endtask

    task automatic measure_latency();
        int      n;
        int      e0;
        vec_wb_t res;
        vec_wb_t exp;

        e0       = errors;
        wb_ready = 1'b1;
        drive_fields(1);
        exp      = expected_wb(op, elem_type, vm_enable, vmask, dest_scalar, rd_idx,
                               src_a, src_b);
        in_valid = 1'b1;
        wait_accept();
        #1;
        in_valid = 1'b0;

        // n is the rising edge after the transfer that the sampled wb_valid belongs to
        n = 1;
        @(negedge clk);
        while (!wb_valid && n < max_wait) begin
            @(negedge clk);
            n++;
        end
        if (!wb_valid) begin
            $display("timeout: wb_valid never rose for the latency request");
            timed_out = 1'b1;
        end else begin
            if (n != 2) begin
                $display("FAILED t=%0t latency got %0d exp 2", $time, n);
                errors++;
            end
            res.data        = wb_data;
            res.rd          = wb_rd;
            res.is_scalar   = wb_is_scalar;
            res.err_illegal = wb_err_illegal;
            check_data(res, exp);
            check_flags(res, exp);
            check_tag(res, exp);
            check_drained();
            $display("test 6 %s 1 request, %0d errors", "latency", errors - e0);
        end
    endtask

    initial begin
        rst_n       = 1'b0;
        in_valid    = 1'b0;
        op          = '0;
        elem_type   = '0;
        vm_enable   = 1'b0;
        vmask       = '0;
        dest_scalar = 1'b0;
        rd_idx      = '0;
        src_a       = '0;
        src_b       = '0;
        wb_ready    = 1'b1;
        errors      = 0;
        timed_out   = 1'b0;
        void'($urandom(seed));

        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        run_test(1, "alu", 1, 1'b0);
        run_test(2, "compare", 2, 1'b0);
        run_test(3, "predication", 3, 1'b0);
        run_test(4, "illegal", 4, 1'b0);
        run_test(5, "backpressure", 5, 1'b1);
        if (!timed_out) begin
            measure_latency();
        end

        $display("%0d tests, %0d errors", n_tests, errors);
        if (errors == 0 && !timed_out) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* vlog.f */
vec_alu_pkg.sv
vec_op_if.sv
vec_stage.sv
vec_alu_ctrl.sv
vec_lane_unpack.sv
vec_lane_alu.sv
vec_result_pack.sv
vec_alu_top.sv
tb_vec_alu.sv

/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_vec_alu
FILELIST  = vlog.f
OBJ_DIR   = obj_dir
SIM       = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
PASS_MSG  = all tests passed
SRCS      = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
